// ==== hdl/nic_pkg.sv ====
/*
 * Shared definitions for the NIC CSR and statistics block.
 * Holds the MMIO address map, field widths, the AFU identity and the
 * packed structs passed between the CSR parts and the testbench.
 */

package nic_pkg;

    // ==================================================
    // Field widths and sizes
    // ==================================================
    localparam int LMAX_NUM_OF_FLOWS = 3;
    localparam int LMAX_CCIP_BATCH   = 4;
    localparam int LMAX_POLLING_RATE = 8;

    // Rate meter window, shortened so a window fits in simulation
    localparam int RPS_WINDOW   = 1024;
    localparam int NUM_COUNTERS = 5;

    typedef logic [15:0] mmio_addr_t;
    typedef logic [63:0] mmio_data_t;
    typedef logic [8:0]  mmio_tid_t;
    typedef logic [41:0] cl_addr_t;
    typedef logic [7:0]  cnt_id_t;
    typedef logic [63:0] cnt_value_t;
    typedef logic [31:0] rps_t;

    typedef logic [LMAX_NUM_OF_FLOWS-1:0] flow_cnt_t;
    typedef logic [LMAX_CCIP_BATCH-1:0]   batch_t;
    typedef logic [LMAX_POLLING_RATE-1:0] poll_rate_t;

    // ==================================================
    // Identity and address map
    // ==================================================
    localparam logic [7:0]   NIC_ID = 8'd3;
    localparam logic [127:0] AFU_ID = 128'h5f3c_1a2e_8b47_4d90_a6c1_3e72_9b05_d418;

    // Feature type AFU in 63:60, end of list in bit 40
    localparam mmio_data_t AFU_DFH = 64'h1000_0100_0000_0000;

    localparam mmio_addr_t AFU_DFH_ADDR  = 16'h0000;
    localparam mmio_addr_t AFU_ID_L_ADDR = 16'h0002;
    localparam mmio_addr_t AFU_ID_H_ADDR = 16'h0004;

    localparam mmio_addr_t CSR_BASE = 16'h0010;

    // Offsets from CSR_BASE, 64-bit words at even addresses
    localparam mmio_addr_t ADDR_MEM_TX    = 16'd0;
    localparam mmio_addr_t ADDR_MEM_RX    = 16'd2;
    localparam mmio_addr_t ADDR_NIC_START = 16'd4;
    localparam mmio_addr_t ADDR_NUM_FLOWS = 16'd6;
    localparam mmio_addr_t ADDR_INIT      = 16'd8;
    localparam mmio_addr_t ADDR_STATUS    = 16'd10;
    localparam mmio_addr_t ADDR_RPS       = 16'd12;
    localparam mmio_addr_t ADDR_CNT_SEL   = 16'd14;
    localparam mmio_addr_t ADDR_CNT_VALUE = 16'd16;
    localparam mmio_addr_t ADDR_TX_BATCH  = 16'd24;
    localparam mmio_addr_t ADDR_POLL_RATE = 16'd28;

    // ==================================================
    // Structs
    // ==================================================
    typedef struct packed {
        logic       rd_valid;
        logic       wr_valid;
        mmio_addr_t address;
        mmio_tid_t  tid;
        mmio_data_t data;
    } mmio_req_t;

    typedef struct packed {
        logic       rd_valid;
        mmio_tid_t  tid;
        mmio_data_t data;
    } mmio_rsp_t;

    typedef struct packed {
        cl_addr_t   tx_base;
        cl_addr_t   rx_base;
        flow_cnt_t  num_flows_m1;
        logic       start;
        batch_t     tx_batch;
        poll_rate_t poll_rate;
    } nic_cfg_t;

    // Counter ids 0 to 4 follow this order
    typedef struct packed {
        logic rx_rpc;
        logic tx_rpc;
        logic tx_drop;
        logic net_tx;
        logic net_rx;
    } nic_events_t;

    typedef struct packed {
        logic ccip_initialized;
        logic rpc_initialized;
        logic err_ccip;
        logic err_rpc;
        logic err_rx_fifo;
        logic err_tx_fifo;
    } nic_health_t;

    typedef struct packed {
        logic [7:0] nic_id;
        logic       ready;
        logic       running;
        logic       error;
        logic       err_ccip;
        logic       err_rpc;
        logic       err_rx_fifo;
        logic       err_tx_fifo;
    } nic_status_t;

endpackage

// ==== hdl/nic_csr_write.sv ====
/*
 * MMIO write side of the NIC CSR block.
 * Decodes host writes into the configuration register file, the
 * counter select register and the one-cycle init strobe.
 */

`timescale 1ns/1ps

module nic_csr_write (
    input  logic               ccip_clk,
    input  logic               reset,

    input  nic_pkg::mmio_req_t mmio_req,

    output nic_pkg::nic_cfg_t  cfg,
    output logic               nic_init,
    output nic_pkg::cnt_id_t   cnt_sel
);

    // ==================================================
    // Write decode
    // ==================================================
    nic_pkg::mmio_data_t wr_data;

    assign wr_data = mmio_req.data;

    always_ff @(posedge ccip_clk) begin
        // Init is a strobe, cleared unless written this cycle
        nic_init <= 1'b0;

        if (mmio_req.wr_valid) begin
            case (mmio_req.address)
                nic_pkg::CSR_BASE + nic_pkg::ADDR_MEM_TX: begin
                    cfg.tx_base <= nic_pkg::cl_addr_t'(wr_data);
                end

                nic_pkg::CSR_BASE + nic_pkg::ADDR_MEM_RX: begin
                    cfg.rx_base <= nic_pkg::cl_addr_t'(wr_data);
                end

                nic_pkg::CSR_BASE + nic_pkg::ADDR_NIC_START: begin
                    cfg.start <= wr_data[0];
                end

                // Host writes the count, hardware keeps count - 1
                nic_pkg::CSR_BASE + nic_pkg::ADDR_NUM_FLOWS: begin
                    cfg.num_flows_m1 <= nic_pkg::flow_cnt_t'(wr_data) - 1'b1;
                end

                nic_pkg::CSR_BASE + nic_pkg::ADDR_INIT: begin
                    nic_init <= 1'b1;
                end

                nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_SEL: begin
                    cnt_sel <= nic_pkg::cnt_id_t'(wr_data);
                end

                nic_pkg::CSR_BASE + nic_pkg::ADDR_TX_BATCH: begin
                    cfg.tx_batch <= nic_pkg::batch_t'(wr_data);
                end

                nic_pkg::CSR_BASE + nic_pkg::ADDR_POLL_RATE: begin
                    cfg.poll_rate <= nic_pkg::poll_rate_t'(wr_data);
                end

                default: begin
                end
            endcase
        end

        if (reset) begin
            cfg      <= '0;
            nic_init <= 1'b0;
            cnt_sel  <= '0;
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    // Host side: one MMIO request kind per cycle
    a_rd_wr_exclusive: assert property (
        @(posedge ccip_clk) disable iff (reset)
        !(mmio_req.rd_valid && mmio_req.wr_valid)
    );

endmodule

// ==== hdl/nic_counters.sv ====
/*
 * Packet event counters and request rate meter.
 * Counts the five event strobes, returns the counter picked by the
 * select register and measures rx_rpc strobes per window.
 */

`timescale 1ns/1ps

module nic_counters #(
    parameter int WINDOW_CYCLES = nic_pkg::RPS_WINDOW
) (
    input  logic                 ccip_clk,
    input  logic                 reset,

    input  nic_pkg::nic_events_t events,
    input  nic_pkg::cnt_id_t     cnt_sel,

    output nic_pkg::cnt_value_t  cnt_value,
    output nic_pkg::rps_t        rps
);

    localparam int WIN_W = $clog2(WINDOW_CYCLES);

    // ==================================================
    // Event counters
    // ==================================================
    logic [nic_pkg::NUM_COUNTERS-1:0] ev_vec;
    nic_pkg::cnt_value_t              cnt_q [nic_pkg::NUM_COUNTERS];

    // Index i is counter id i
    assign ev_vec[0] = events.rx_rpc;
    assign ev_vec[1] = events.tx_rpc;
    assign ev_vec[2] = events.tx_drop;
    assign ev_vec[3] = events.net_tx;
    assign ev_vec[4] = events.net_rx;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            for (int i = 0; i < nic_pkg::NUM_COUNTERS; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < nic_pkg::NUM_COUNTERS; i++) begin
                if (ev_vec[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // Unknown ids fall through to zero
    always_comb begin
        cnt_value = '0;
        for (int i = 0; i < nic_pkg::NUM_COUNTERS; i++) begin
            if (cnt_sel == nic_pkg::cnt_id_t'(i)) begin
                cnt_value = cnt_q[i];
            end
        end
    end

    // ==================================================
    // Rate meter
    // ==================================================
    logic [WIN_W-1:0] win_cnt;
    nic_pkg::rps_t    rate_cnt;
    logic             win_end;

    assign win_end = (win_cnt == WIN_W'(WINDOW_CYCLES - 1));

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            win_cnt  <= '0;
            rate_cnt <= '0;
            rps      <= '0;
        end else if (win_end) begin
            // Last sample of the window goes straight into rps
            rps      <= rate_cnt + nic_pkg::rps_t'(events.rx_rpc);
            rate_cnt <= '0;
            win_cnt  <= '0;
        end else begin
            rate_cnt <= rate_cnt + nic_pkg::rps_t'(events.rx_rpc);
            win_cnt  <= win_cnt + 1'b1;
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    // At most one strobe per cycle, so a window cannot hold more
    a_rps_bound: assert property (
        @(posedge ccip_clk) disable iff (reset)
        rps <= nic_pkg::rps_t'(WINDOW_CYCLES)
    );

endmodule

// ==== hdl/nic_csr_read.sv ====
/*
 * MMIO read side of the NIC CSR block.
 * Registers the status word from the health levels and the start flag,
 * and answers every host read one cycle later with its tid.
 */

`timescale 1ns/1ps

module nic_csr_read (
    input  logic                 ccip_clk,
    input  logic                 reset,

    input  nic_pkg::mmio_req_t   mmio_req,
    input  nic_pkg::nic_health_t health,
    input  logic                 start,
    input  nic_pkg::cnt_value_t  cnt_value,
    input  nic_pkg::rps_t        rps,

    output nic_pkg::mmio_rsp_t   mmio_rsp
);

    // ==================================================
    // Status register
    // ==================================================
    nic_pkg::nic_status_t status;
    logic                 sys_ready;

    assign sys_ready = health.ccip_initialized & health.rpc_initialized;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            status <= '0;
        end else begin
            status.nic_id  <= nic_pkg::NIC_ID;
            status.ready   <= sys_ready;
            status.running <= sys_ready & start;

            status.err_ccip    <= health.err_ccip;
            status.err_rpc     <= health.err_rpc;
            status.err_rx_fifo <= health.err_rx_fifo;
            status.err_tx_fifo <= health.err_tx_fifo;
            status.error       <= health.err_ccip | health.err_rpc |
                                  health.err_rx_fifo | health.err_tx_fifo;
        end
    end

    // ==================================================
    // Read mux
    // ==================================================
    nic_pkg::mmio_data_t rd_data;

    always_comb begin
        case (mmio_req.address)
            nic_pkg::AFU_DFH_ADDR:  rd_data = nic_pkg::AFU_DFH;
            nic_pkg::AFU_ID_L_ADDR: rd_data = nic_pkg::AFU_ID[63:0];
            nic_pkg::AFU_ID_H_ADDR: rd_data = nic_pkg::AFU_ID[127:64];

            // Narrow registers are right-aligned
            nic_pkg::CSR_BASE + nic_pkg::ADDR_STATUS: rd_data = nic_pkg::mmio_data_t'(status);
            nic_pkg::CSR_BASE + nic_pkg::ADDR_RPS:    rd_data = nic_pkg::mmio_data_t'(rps);
            nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_VALUE: rd_data = cnt_value;

            default: rd_data = '0;
        endcase
    end

    // Every read is answered, no back-pressure
    always_ff @(posedge ccip_clk) begin
        mmio_rsp.rd_valid <= mmio_req.rd_valid;
        mmio_rsp.tid      <= mmio_req.tid;
        mmio_rsp.data     <= rd_data;

        if (reset) begin
            mmio_rsp.rd_valid <= 1'b0;
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    a_rsp_follows_req: assert property (
        @(posedge ccip_clk) disable iff (reset)
        mmio_rsp.rd_valid |-> $past(mmio_req.rd_valid)
    );

endmodule

// ==== hdl/nic_csr_top.sv ====
/*
 * Top level of the NIC CSR and statistics block.
 * Joins the write decode, the counters and the read side on ccip_clk.
 */

`timescale 1ns/1ps

module nic_csr_top (
    input  logic                 ccip_clk,
    input  logic                 reset,

    // Host MMIO
    input  nic_pkg::mmio_req_t   mmio_req,
    output nic_pkg::mmio_rsp_t   mmio_rsp,

    // From transport and RPC layers
    input  nic_pkg::nic_events_t nic_events,
    input  nic_pkg::nic_health_t nic_health,

    // To transport and RPC layers
    output nic_pkg::nic_cfg_t    cfg,
    output logic                 nic_init
);

    nic_pkg::cnt_id_t    cnt_sel;
    nic_pkg::cnt_value_t cnt_value;
    nic_pkg::rps_t       rps;

    // ==================================================
    // Input side
    // ==================================================
    nic_csr_write u_csr_write (
        .ccip_clk (ccip_clk),
        .reset    (reset),
        .mmio_req (mmio_req),
        .cfg      (cfg),
        .nic_init (nic_init),
        .cnt_sel  (cnt_sel)
    );

    // ==================================================
    // Counters and rate meter
    // ==================================================
    nic_counters #(
        .WINDOW_CYCLES (nic_pkg::RPS_WINDOW)
    ) u_counters (
        .ccip_clk  (ccip_clk),
        .reset     (reset),
        .events    (nic_events),
        .cnt_sel   (cnt_sel),
        .cnt_value (cnt_value),
        .rps       (rps)
    );

    // ==================================================
    // Output side
    // ==================================================
    nic_csr_read u_csr_read (
        .ccip_clk  (ccip_clk),
        .reset     (reset),
        .mmio_req  (mmio_req),
        .health    (nic_health),
        .start     (cfg.start),
        .cnt_value (cnt_value),
        .rps       (rps),
        .mmio_rsp  (mmio_rsp)
    );

endmodule

// ==== sim/nic_csr_tb.sv ====
/*
 * Testbench for the NIC CSR and statistics block.
 * Drives MMIO reads and writes, event strobes and health levels, keeps a
 * model of the register contents and checks every read response.
 */

`timescale 1ns/1ps

module nic_csr_tb;

    localparam int TIMEOUT_CYCLES = 12 * nic_pkg::RPS_WINDOW;

    localparam int EV_IDLE    = 0;
    localparam int EV_RANDOM  = 1;
    localparam int EV_EVERY   = 2;
    localparam int EV_QUARTER = 3;

    logic                 ccip_clk = 1'b0;
    logic                 reset;
    nic_pkg::mmio_req_t   mmio_req;
    nic_pkg::mmio_rsp_t   mmio_rsp;
    nic_pkg::nic_events_t nic_events;
    nic_pkg::nic_health_t nic_health;
    nic_pkg::nic_cfg_t    cfg;
    logic                 nic_init;

    // Model of the register contents
    nic_pkg::cl_addr_t    tx_base_m;
    nic_pkg::cl_addr_t    rx_base_m;
    nic_pkg::flow_cnt_t   flows_m1_m;
    logic                 start_m;
    nic_pkg::batch_t      batch_m;
    nic_pkg::poll_rate_t  poll_m;
    nic_pkg::cnt_id_t     sel_m;
    nic_pkg::nic_health_t health_m;
    nic_pkg::rps_t        rps_m;
    nic_pkg::cnt_value_t  ev_count [nic_pkg::NUM_COUNTERS];

    nic_pkg::mmio_data_t  exp_data_q [$];
    nic_pkg::mmio_tid_t   exp_tid_q [$];
    logic [4:0]           rand_ev_q [$];
    nic_pkg::mmio_data_t  rsp_want_data;
    nic_pkg::mmio_tid_t   rsp_want_tid;

    int          ev_mode = EV_IDLE;
    logic        checks_on = 1'b0;
    logic        rd_seen = 1'b0;
    logic        init_seen = 1'b0;
    int          init_expected = 0;
    int          init_pulses = 0;
    int          rsp_errors = 0;
    int          seq_errors = 0;
    int          cycle_count = 0;

    always #10 ccip_clk = ~ccip_clk;

    nic_csr_top UUT (
        .ccip_clk   (ccip_clk),
        .reset      (reset),
        .mmio_req   (mmio_req),
        .mmio_rsp   (mmio_rsp),
        .nic_events (nic_events),
        .nic_health (nic_health),
        .cfg        (cfg),
        .nic_init   (nic_init)
    );

    // ==================================================
    // Reference model
    // ==================================================
    function automatic nic_pkg::mmio_data_t expected_read(input nic_pkg::mmio_addr_t addr);
        nic_pkg::mmio_data_t d;
        logic                ready;
        logic                err;
        d     = '0;
        ready = health_m.ccip_initialized & health_m.rpc_initialized;
        err   = health_m.err_ccip | health_m.err_rpc | health_m.err_rx_fifo |
                health_m.err_tx_fifo;
        case (addr)
            // AFU feature type 1, end of list bit 40
            16'h0000: d = (64'd1 << 60) | (64'd1 << 40);
            16'h0002: d = nic_pkg::AFU_ID[63:0];
            16'h0004: d = nic_pkg::AFU_ID[127:64];
            nic_pkg::CSR_BASE + nic_pkg::ADDR_STATUS: begin
                d = {49'd0, nic_pkg::NIC_ID, ready, ready & start_m, err,
                     health_m.err_ccip, health_m.err_rpc, health_m.err_rx_fifo,
                     health_m.err_tx_fifo};
            end
            nic_pkg::CSR_BASE + nic_pkg::ADDR_RPS: d = {32'd0, rps_m};
            nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_VALUE: begin
                if (sel_m < nic_pkg::cnt_id_t'(nic_pkg::NUM_COUNTERS)) begin
                    d = ev_count[sel_m[2:0]];
                end
            end
            default: d = '0;
        endcase
        return d;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, want);
    endtask

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge ccip_clk);
    endtask

    task automatic mmio_write(input nic_pkg::mmio_addr_t addr, input nic_pkg::mmio_data_t data);
        @(negedge ccip_clk);
        mmio_req.wr_valid = 1'b1;
        mmio_req.address  = addr;
        mmio_req.tid      = '0;
        mmio_req.data     = data;
        @(negedge ccip_clk);
        mmio_req.wr_valid = 1'b0;
        case (addr)
            nic_pkg::CSR_BASE + nic_pkg::ADDR_MEM_TX:    tx_base_m = nic_pkg::cl_addr_t'(data);
            nic_pkg::CSR_BASE + nic_pkg::ADDR_MEM_RX:    rx_base_m = nic_pkg::cl_addr_t'(data);
            nic_pkg::CSR_BASE + nic_pkg::ADDR_NIC_START: start_m = data[0];
            nic_pkg::CSR_BASE + nic_pkg::ADDR_NUM_FLOWS: begin
                flows_m1_m = nic_pkg::flow_cnt_t'(data - 64'd1);
            end
            nic_pkg::CSR_BASE + nic_pkg::ADDR_INIT:      init_expected++;
            nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_SEL:   sel_m = nic_pkg::cnt_id_t'(data);
            nic_pkg::CSR_BASE + nic_pkg::ADDR_TX_BATCH:  batch_m = nic_pkg::batch_t'(data);
            nic_pkg::CSR_BASE + nic_pkg::ADDR_POLL_RATE: poll_m = nic_pkg::poll_rate_t'(data);
            default: begin
            end
        endcase
    endtask

    task automatic mmio_read(input nic_pkg::mmio_addr_t addr);
        nic_pkg::mmio_tid_t tid;
        tid = nic_pkg::mmio_tid_t'($urandom);
        @(negedge ccip_clk);
        mmio_req.rd_valid = 1'b1;
        mmio_req.address  = addr;
        mmio_req.tid      = tid;
        mmio_req.data     = '0;
        exp_data_q.push_back(expected_read(addr));
        exp_tid_q.push_back(tid);
        @(negedge ccip_clk);
        mmio_req.rd_valid = 1'b0;
    endtask

    task automatic wait_responses();
        while (exp_tid_q.size() != 0) begin
            @(negedge ccip_clk);
        end
        @(negedge ccip_clk);
    endtask

    task automatic set_health(input nic_pkg::nic_health_t h);
        @(negedge ccip_clk);
        nic_health = h;
        health_m   = h;
        // Status is registered, give it time to settle
        wait_cycles(2);
    endtask

    task automatic check_cfg();
        if (cfg.tx_base !== tx_base_m) begin
            report_mismatch("cfg.tx_base", 64'(cfg.tx_base), 64'(tx_base_m));
            seq_errors++;
        end
        if (cfg.rx_base !== rx_base_m) begin
            report_mismatch("cfg.rx_base", 64'(cfg.rx_base), 64'(rx_base_m));
            seq_errors++;
        end
        if (cfg.num_flows_m1 !== flows_m1_m) begin
            report_mismatch("cfg.num_flows_m1", 64'(cfg.num_flows_m1), 64'(flows_m1_m));
            seq_errors++;
        end
        if (cfg.start !== start_m) begin
            report_mismatch("cfg.start", 64'(cfg.start), 64'(start_m));
            seq_errors++;
        end
        if (cfg.tx_batch !== batch_m) begin
            report_mismatch("cfg.tx_batch", 64'(cfg.tx_batch), 64'(batch_m));
            seq_errors++;
        end
        if (cfg.poll_rate !== poll_m) begin
            report_mismatch("cfg.poll_rate", 64'(cfg.poll_rate), 64'(poll_m));
            seq_errors++;
        end
    endtask

    task automatic config_write(input nic_pkg::mmio_addr_t addr, input nic_pkg::mmio_data_t data);
        mmio_write(addr, data);
        check_cfg();
    endtask

    // ==================================================
    // Event strobe driver
    // ==================================================
    initial begin
        logic [1:0] phase;
        phase      = '0;
        nic_events = '0;
        for (int i = 0; i < nic_pkg::NUM_COUNTERS; i++) begin
            ev_count[i] = '0;
        end
        forever begin
            @(negedge ccip_clk);
            nic_events = '0;
            case (ev_mode)
                EV_RANDOM: begin
                    if (rand_ev_q.size() != 0) begin
                        nic_events = nic_pkg::nic_events_t'(rand_ev_q.pop_front());
                    end
                end
                EV_EVERY:   nic_events.rx_rpc = 1'b1;
                EV_QUARTER: begin
                    nic_events.rx_rpc = (phase == 2'd0);
                    phase = phase + 2'd1;
                end
                default: begin
                end
            endcase
            if (nic_events.rx_rpc)  ev_count[0] = ev_count[0] + 64'd1;
            if (nic_events.tx_rpc)  ev_count[1] = ev_count[1] + 64'd1;
            if (nic_events.tx_drop) ev_count[2] = ev_count[2] + 64'd1;
            if (nic_events.net_tx)  ev_count[3] = ev_count[3] + 64'd1;
            if (nic_events.net_rx)  ev_count[4] = ev_count[4] + 64'd1;
        end
    end

    // ==================================================
    // Response and strobe checker
    // ==================================================
    always @(posedge ccip_clk) begin
        rd_seen   <= mmio_req.rd_valid;
        init_seen <= mmio_req.wr_valid &&
                     (mmio_req.address == nic_pkg::CSR_BASE + nic_pkg::ADDR_INIT);
    end

    always @(negedge ccip_clk) begin
        if (checks_on) begin
            if (mmio_rsp.rd_valid !== rd_seen) begin
                report_mismatch("mmio_rsp.rd_valid", 64'(mmio_rsp.rd_valid), 64'(rd_seen));
                rsp_errors++;
            end
            if (mmio_rsp.rd_valid === 1'b1) begin
                if (exp_tid_q.size() == 0) begin
                    $display("error at %0t ns: read response with no read outstanding", $time);
                    rsp_errors++;
                end else begin
                    rsp_want_data = exp_data_q.pop_front();
                    rsp_want_tid  = exp_tid_q.pop_front();
                    if (mmio_rsp.tid !== rsp_want_tid) begin
                        report_mismatch("mmio_rsp.tid", 64'(mmio_rsp.tid), 64'(rsp_want_tid));
                        rsp_errors++;
                    end
                    if (mmio_rsp.data !== rsp_want_data) begin
                        report_mismatch("mmio_rsp.data", mmio_rsp.data, rsp_want_data);
                        rsp_errors++;
                    end
                end
            end
            if (nic_init !== init_seen) begin
                report_mismatch("nic_init", 64'(nic_init), 64'(init_seen));
                rsp_errors++;
            end
            if (nic_init === 1'b1) begin
                init_pulses++;
            end
        end
    end

    // Longest run is about 7000 cycles, limit leaves margin
    always @(posedge ccip_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: response %0d, sequence %0d", rsp_errors, seq_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        void'($urandom(32'habc3));
        reset      = 1'b1;
        mmio_req   = '0;
        nic_health = '0;
        health_m   = '0;
        tx_base_m  = '0;
        rx_base_m  = '0;
        flows_m1_m = '0;
        start_m    = 1'b0;
        batch_m    = '0;
        poll_m     = '0;
        sel_m      = '0;
        rps_m      = '0;
        repeat (10) @(negedge ccip_clk);
        reset = 1'b0;
        @(posedge ccip_clk);
        checks_on = 1'b1;

        // AFU header, ID halves, empty header words and an unmapped word
        mmio_read(16'h0000);
        mmio_read(16'h0002);
        mmio_read(16'h0004);
        mmio_read(16'h0006);
        mmio_read(16'h0008);
        mmio_read(16'h1000 | nic_pkg::mmio_addr_t'($urandom & 32'h0ffe));
        wait_responses();

        // Configuration registers
        for (int i = 0; i < 4; i++) begin
            config_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_MEM_TX, {$urandom, $urandom});
            config_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_MEM_RX, {$urandom, $urandom});
            config_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_NUM_FLOWS,
                         64'(32'd1 + $urandom % 32'd7));
            config_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_TX_BATCH, 64'($urandom));
            config_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_POLL_RATE, 64'($urandom));
            config_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_NIC_START, 64'($urandom & 32'd1));
        end

        // Init strobes, checked every cycle by the checker
        mmio_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_INIT, 64'd1);
        wait_cycles(5);
        mmio_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_INIT, {$urandom, $urandom});
        wait_cycles(3);

        // Status for random health, first pass fully ready and started
        for (int i = 0; i < 10; i++) begin
            if (i == 0) begin
                mmio_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_NIC_START, 64'd1);
                set_health(nic_pkg::nic_health_t'(6'b110000));
            end else begin
                mmio_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_NIC_START, 64'($urandom & 32'd1));
                set_health(nic_pkg::nic_health_t'($urandom));
            end
            mmio_read(nic_pkg::CSR_BASE + nic_pkg::ADDR_STATUS);
            wait_responses();
        end

        // Random event strobes, then read every counter and one unused id
        for (int i = 0; i < 400; i++) begin
            rand_ev_q.push_back(5'($urandom));
        end
        @(posedge ccip_clk);
        ev_mode = EV_RANDOM;
        while (rand_ev_q.size() != 0) begin
            @(negedge ccip_clk);
        end
        @(posedge ccip_clk);
        ev_mode = EV_IDLE;
        wait_cycles(2);
        for (int id = 0; id < nic_pkg::NUM_COUNTERS; id++) begin
            mmio_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_SEL, 64'(id));
            mmio_read(nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_VALUE);
        end
        mmio_write(nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_SEL, 64'd7);
        mmio_read(nic_pkg::CSR_BASE + nic_pkg::ADDR_CNT_VALUE);
        wait_responses();

        // Rate meter, full rate then quarter rate
        @(posedge ccip_clk);
        ev_mode = EV_EVERY;
        wait_cycles(3 * nic_pkg::RPS_WINDOW);
        rps_m = nic_pkg::rps_t'(nic_pkg::RPS_WINDOW);
        mmio_read(nic_pkg::CSR_BASE + nic_pkg::ADDR_RPS);
        wait_responses();
        @(posedge ccip_clk);
        ev_mode = EV_QUARTER;
        wait_cycles(3 * nic_pkg::RPS_WINDOW);
        rps_m = nic_pkg::rps_t'(nic_pkg::RPS_WINDOW / 4);
        mmio_read(nic_pkg::CSR_BASE + nic_pkg::ADDR_RPS);
        wait_responses();
        @(posedge ccip_clk);
        ev_mode = EV_IDLE;
        wait_cycles(4);

        if (init_pulses != init_expected) begin
            $display("error at %0t ns: nic_init pulses got %0d expected %0d",
                     $time, init_pulses, init_expected);
            seq_errors++;
        end

        $display("errors: response %0d, sequence %0d", rsp_errors, seq_errors);
        if (rsp_errors == 0 && seq_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== nic_csr.f ====
hdl/nic_pkg.sv
hdl/nic_csr_write.sv
hdl/nic_counters.sv
hdl/nic_csr_read.sv
hdl/nic_csr_top.sv
sim/nic_csr_tb.sv

// ==== Makefile ====
# Verilator build and run for the NIC CSR block

TOP = nic_csr_tb
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f nic_csr.f -Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log
